// File: files.f
hw/l15_arb_pkg.sv
hw/arb_fsm.sv
hw/l15_req_mux.sv
hw/l15_resp_router.sv
hw/l15_port_arbiter.sv
verification/tb_l15_port_arbiter.sv

// File: Makefile
# Verilator flow for the L1.5 port arbiter

VERILATOR ?= verilator
FILELIST  ?= files.f
TB_TOP    ?= tb_l15_port_arbiter
RTL_TOP   ?= l15_port_arbiter
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Verification passed

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation result: PASS"; \
	else \
		echo "Simulation result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/tb_l15_port_arbiter.sv
`timescale 1ns/100ps

module tb_l15_port_arbiter;

	localparam int PERIOD        = 4;
	localparam int RST_CYCLES    = 4;
	localparam int MARGIN_CYCLES = 20;

	// One table row: inputs for a cycle and the expected state of the port
	typedef struct packed
	{
		logic                    mem_pending;
		logic                    fetch_hold;
		logic                    fetch_wait_resp;
		logic                    mem_done;
		l15_arb_pkg::l15_req_t   fetch_req;
		l15_arb_pkg::l15_req_t   mem_req;
		l15_arb_pkg::l15_resp_t  cache_resp;
		l15_arb_pkg::l15_ack_t   cache_ack;
		logic                    fetch_req_ack;
		logic                    mem_req_ack;
		logic                    exp_stall;
		logic                    exp_granted;
		l15_arb_pkg::arb_state_t exp_owner; // Client that owns the port in this cycle
	} row_t;

	logic clk;
	logic nrst;

	l15_arb_pkg::l15_req_t  fetch_req;
	logic                   fetch_req_ack;
	l15_arb_pkg::l15_ack_t  fetch_ack;
	l15_arb_pkg::l15_resp_t fetch_resp;
	l15_arb_pkg::l15_req_t  mem_req;
	logic                   mem_req_ack;
	l15_arb_pkg::l15_ack_t  mem_ack;
	l15_arb_pkg::l15_resp_t mem_resp;
	l15_arb_pkg::l15_req_t  cache_req;
	logic                   cache_req_ack;
	l15_arb_pkg::l15_ack_t  cache_ack;
	l15_arb_pkg::l15_resp_t cache_resp;
	logic                   mem_pending;
	logic                   fetch_hold;
	logic                   fetch_wait_resp;
	logic                   mem_done;
	logic                   mem_stall;
	logic                   mem_granted;

	row_t   rows[$];
	integer seed = 42;
	int     checks = 0;
	int     errors = 0;
	int     cur_row = -1;

	l15_port_arbiter UUT
	(
		.clk             (clk),
		.nrst            (nrst),
		.fetch_req       (fetch_req),
		.fetch_req_ack   (fetch_req_ack),
		.fetch_ack       (fetch_ack),
		.fetch_resp      (fetch_resp),
		.mem_req         (mem_req),
		.mem_req_ack     (mem_req_ack),
		.mem_ack         (mem_ack),
		.mem_resp        (mem_resp),
		.cache_req       (cache_req),
		.cache_req_ack   (cache_req_ack),
		.cache_ack       (cache_ack),
		.cache_resp      (cache_resp),
		.mem_pending     (mem_pending),
		.fetch_hold      (fetch_hold),
		.fetch_wait_resp (fetch_wait_resp),
		.mem_done        (mem_done),
		.mem_stall       (mem_stall),
		.mem_granted     (mem_granted)
	);

	always #(PERIOD/2) clk = ~clk;

	task automatic draw_bits(output logic [255:0] bits);
		for (int i = 0; i < 8; i++)
			bits[i*32 +: 32] = $random(seed);
	endtask

	// ctrl is {mem_pending, fetch_hold, fetch_wait_resp, mem_done}
	// vals is {fetch_req.val, mem_req.val, cache_resp.val}, flags is {stall, granted}
	task automatic add_row(input logic [3:0] ctrl, input logic [2:0] vals,
		input logic [1:0] flags, input l15_arb_pkg::arb_state_t owner);
		row_t         r;
		logic [255:0] bits;
		draw_bits(bits);
		r.fetch_req = bits[104:0];
		draw_bits(bits);
		r.mem_req = bits[104:0];
		draw_bits(bits);
		r.cache_resp    = bits[132:0];
		r.cache_ack     = bits[134:133];
		r.fetch_req_ack = bits[135];
		r.mem_req_ack   = bits[136];
		{r.mem_pending, r.fetch_hold, r.fetch_wait_resp, r.mem_done} = ctrl;
		{r.fetch_req.val, r.mem_req.val, r.cache_resp.val} = vals;
		{r.exp_stall, r.exp_granted} = flags;
		r.exp_owner = owner;
		rows.push_back(r);
	endtask

	task automatic build_table();
		// After reset fetch passes straight through
		add_row(4'b0000, 3'b111, 2'b00, l15_arb_pkg::ARB_FETCH);
		add_row(4'b0010, 3'b101, 2'b00, l15_arb_pkg::ARB_FETCH);
		// Held front end blocks the switch
		add_row(4'b1100, 3'b110, 2'b00, l15_arb_pkg::ARB_FETCH);
		add_row(4'b1100, 3'b111, 2'b00, l15_arb_pkg::ARB_FETCH);
		add_row(4'b1000, 3'b110, 2'b00, l15_arb_pkg::ARB_FETCH); // Switch starts here
		add_row(4'b1010, 3'b110, 2'b10, l15_arb_pkg::ARB_WAIT);
		// Drain of the outstanding fetch
		add_row(4'b1010, 3'b110, 2'b10, l15_arb_pkg::ARB_WAIT);
		add_row(4'b1000, 3'b111, 2'b10, l15_arb_pkg::ARB_WAIT); // Response without a waiter
		add_row(4'b1010, 3'b111, 2'b10, l15_arb_pkg::ARB_WAIT);
		// Data grant, flags lag entry by one cycle
		add_row(4'b1000, 3'b110, 2'b10, l15_arb_pkg::ARB_MEM);
		add_row(4'b1000, 3'b011, 2'b01, l15_arb_pkg::ARB_MEM);
		add_row(4'b1000, 3'b110, 2'b01, l15_arb_pkg::ARB_MEM);
		// Done with another op pending keeps the grant
		add_row(4'b1001, 3'b111, 2'b01, l15_arb_pkg::ARB_MEM);
		add_row(4'b0001, 3'b011, 2'b01, l15_arb_pkg::ARB_MEM);
		add_row(4'b0000, 3'b101, 2'b00, l15_arb_pkg::ARB_FETCH);
		// Second data access right after the return
		add_row(4'b1000, 3'b110, 2'b00, l15_arb_pkg::ARB_FETCH);
		add_row(4'b1010, 3'b111, 2'b10, l15_arb_pkg::ARB_WAIT);
		add_row(4'b1000, 3'b110, 2'b10, l15_arb_pkg::ARB_MEM);
		add_row(4'b1000, 3'b011, 2'b01, l15_arb_pkg::ARB_MEM);
		add_row(4'b0001, 3'b110, 2'b01, l15_arb_pkg::ARB_MEM);
		add_row(4'b0000, 3'b101, 2'b00, l15_arb_pkg::ARB_FETCH);
		add_row(4'b0000, 3'b111, 2'b00, l15_arb_pkg::ARB_FETCH);
	endtask

	task automatic apply_row(input row_t r);
		mem_pending     = r.mem_pending;
		fetch_hold      = r.fetch_hold;
		fetch_wait_resp = r.fetch_wait_resp;
		mem_done        = r.mem_done;
		fetch_req       = r.fetch_req;
		mem_req         = r.mem_req;
		cache_resp      = r.cache_resp;
		cache_ack       = r.cache_ack;
		fetch_req_ack   = r.fetch_req_ack;
		mem_req_ack     = r.mem_req_ack;
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("Fail at %0t ns (row %0d): %s expected %0h, got %0h",
				$time, cur_row, name, exp, got);
		end
	endtask

	task automatic check_word(input string name, input logic [l15_arb_pkg::DATA_W-1:0] got,
		input logic [l15_arb_pkg::DATA_W-1:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("Fail at %0t ns (row %0d): %s expected %0h, got %0h",
				$time, cur_row, name, exp, got);
		end
	endtask

	task automatic check_row(input row_t r);
		logic                  data_owns;
		logic                  fetch_owns;
		l15_arb_pkg::l15_req_t exp_req;
		l15_arb_pkg::l15_ack_t exp_fetch_ack;
		l15_arb_pkg::l15_ack_t exp_mem_ack;
		data_owns  = (r.exp_owner == l15_arb_pkg::ARB_MEM);
		fetch_owns = (r.exp_owner == l15_arb_pkg::ARB_FETCH);
		// Wait state shows the fetch fields with val forced low
		exp_req       = data_owns ? r.mem_req : r.fetch_req;
		exp_req.val   = data_owns ? r.mem_req.val : (fetch_owns && r.fetch_req.val);
		exp_fetch_ack = fetch_owns ? r.cache_ack : 2'b00;
		exp_mem_ack   = data_owns ? r.cache_ack : 2'b00;

		check_bit("mem_stall", mem_stall, r.exp_stall);
		check_bit("mem_granted", mem_granted, r.exp_granted);
		check_bit("cache_req.val", cache_req.val, exp_req.val);
		check_word("cache_req.rqtype", cache_req.rqtype, exp_req.rqtype);
		check_word("cache_req.size", cache_req.size, exp_req.size);
		check_word("cache_req.address", cache_req.address, exp_req.address);
		check_word("cache_req.data", cache_req.data, exp_req.data);
		check_bit("fetch_resp.val", fetch_resp.val, r.cache_resp.val && !data_owns);
		check_bit("mem_resp.val", mem_resp.val, r.cache_resp.val && data_owns);
		// Payload must reach the client that receives responses
		if (data_owns)
		begin
			check_word("mem_resp.data_0", mem_resp.data_0, r.cache_resp.data_0);
			check_word("mem_resp.data_1", mem_resp.data_1, r.cache_resp.data_1);
			check_word("mem_resp.returntype", mem_resp.returntype, r.cache_resp.returntype);
		end
		else
		begin
			check_word("fetch_resp.data_0", fetch_resp.data_0, r.cache_resp.data_0);
			check_word("fetch_resp.data_1", fetch_resp.data_1, r.cache_resp.data_1);
			check_word("fetch_resp.returntype", fetch_resp.returntype,
				r.cache_resp.returntype);
		end
		check_bit("fetch_ack.ack", fetch_ack.ack, exp_fetch_ack.ack);
		check_bit("fetch_ack.header_ack", fetch_ack.header_ack, exp_fetch_ack.header_ack);
		check_bit("mem_ack.ack", mem_ack.ack, exp_mem_ack.ack);
		check_bit("mem_ack.header_ack", mem_ack.header_ack, exp_mem_ack.header_ack);
		check_bit("cache_req_ack", cache_req_ack,
			data_owns ? r.mem_req_ack : r.fetch_req_ack);
	endtask

	initial
	begin
		build_table();
		clk             = 1'b0;
		nrst            = 1'b0;
		fetch_req       = '0;
		fetch_req_ack   = 1'b0;
		mem_req         = '0;
		mem_req_ack     = 1'b0;
		cache_ack       = '0;
		cache_resp      = '0;
		mem_pending     = 1'b0;
		fetch_hold      = 1'b0;
		fetch_wait_resp = 1'b0;
		mem_done        = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		nrst = 1'b1;

		foreach (rows[i])
		begin
			@(posedge clk);
			#1;
			cur_row = i;
			apply_row(rows[i]);
			#2; // Outputs settled, next edge still ahead
			check_row(rows[i]);
		end

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial
	begin : watchdog
		int limit;
		#1;
		limit = (RST_CYCLES + rows.size() + MARGIN_CYCLES) * PERIOD;
		#(limit);
		$display("Watchdog expired before the table was finished, stuck near row %0d", cur_row);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		$display("Verification failed");
		$finish;
	end

endmodule

// File: hw/l15_port_arbiter.sv
`timescale 1ns/100ps

module l15_port_arbiter
(
	input  logic                  clk,
	input  logic                  nrst,

	// Instruction fetch client
	input  l15_arb_pkg::l15_req_t  fetch_req,
	input  logic                  fetch_req_ack,
	output l15_arb_pkg::l15_ack_t  fetch_ack,
	output l15_arb_pkg::l15_resp_t fetch_resp,

	// Data memory client
	input  l15_arb_pkg::l15_req_t  mem_req,
	input  logic                  mem_req_ack,
	output l15_arb_pkg::l15_ack_t  mem_ack,
	output l15_arb_pkg::l15_resp_t mem_resp,

	// L1.5 cache port
	output l15_arb_pkg::l15_req_t  cache_req,
	output logic                  cache_req_ack,
	input  l15_arb_pkg::l15_ack_t  cache_ack,
	input  l15_arb_pkg::l15_resp_t cache_resp,

	// Core control
	input  logic                  mem_pending,
	input  logic                  fetch_hold,
	input  logic                  fetch_wait_resp,
	input  logic                  mem_done,
	output logic                  mem_stall,
	output logic                  mem_granted
);

	l15_arb_pkg::arb_state_t state; // Shared by both steering blocks

	arb_fsm u_fsm
	(
		.clk             (clk),
		.nrst            (nrst),
		.mem_pending     (mem_pending),
		.fetch_hold      (fetch_hold),
		.fetch_wait_resp (fetch_wait_resp),
		.mem_done        (mem_done),
		.resp_val        (cache_resp.val),
		.state           (state),
		.mem_stall       (mem_stall),
		.mem_granted     (mem_granted)
	);

	l15_req_mux u_req_mux
	(
		.state     (state),
		.fetch_req (fetch_req),
		.mem_req   (mem_req),
		.cache_ack (cache_ack),
		.cache_req (cache_req),
		.fetch_ack (fetch_ack),
		.mem_ack   (mem_ack)
	);

	l15_resp_router u_resp_router
	(
		.state         (state),
		.cache_resp    (cache_resp),
		.fetch_req_ack (fetch_req_ack),
		.mem_req_ack   (mem_req_ack),
		.fetch_resp    (fetch_resp),
		.mem_resp      (mem_resp),
		.cache_req_ack (cache_req_ack)
	);

endmodule

// File: hw/l15_resp_router.sv
`timescale 1ns/100ps

module l15_resp_router
(
	input  l15_arb_pkg::arb_state_t state,

	input  l15_arb_pkg::l15_resp_t  cache_resp,

	// Response accepts from the clients
	input  logic                   fetch_req_ack,
	input  logic                   mem_req_ack,

	output l15_arb_pkg::l15_resp_t  fetch_resp,
	output l15_arb_pkg::l15_resp_t  mem_resp,
	output logic                   cache_req_ack
);

	logic to_mem; // Data client owns the response path

	assign to_mem = (state == l15_arb_pkg::ARB_MEM);

	always_comb
	begin
		// Payload goes to both, only val selects the owner
		fetch_resp     = cache_resp;
		mem_resp       = cache_resp;
		fetch_resp.val = cache_resp.val && !to_mem;
		mem_resp.val   = cache_resp.val && to_mem;
	end

	// Fetch keeps answering until the data grant starts
	assign cache_req_ack = to_mem ? mem_req_ack : fetch_req_ack;

	always_comb
	begin
		assert (!(fetch_resp.val && mem_resp.val))
			else $error("response routed to both clients");
	end

endmodule

// File: hw/l15_req_mux.sv
`timescale 1ns/100ps

module l15_req_mux
(
	input  l15_arb_pkg::arb_state_t state,

	// Client requests
	input  l15_arb_pkg::l15_req_t   fetch_req,
	input  l15_arb_pkg::l15_req_t   mem_req,

	// Acks from the cache
	input  l15_arb_pkg::l15_ack_t   cache_ack,

	output l15_arb_pkg::l15_req_t   cache_req,
	output l15_arb_pkg::l15_ack_t   fetch_ack,
	output l15_arb_pkg::l15_ack_t   mem_ack
);

	always_comb
	begin
		cache_req = fetch_req;
		fetch_ack = '0;
		mem_ack   = '0;
		case (state)
			l15_arb_pkg::ARB_FETCH:
			begin
				cache_req = fetch_req;
				fetch_ack = cache_ack;
			end
			l15_arb_pkg::ARB_MEM:
			begin
				cache_req = mem_req;
				mem_ack   = cache_ack;
			end
			default:
			begin
				// Look busy to both clients while fetch drains
				cache_req     = fetch_req;
				cache_req.val = 1'b0;
			end
		endcase
	end

	// Nothing may be issued to the cache during a switch
	always_comb
	begin
		if (state == l15_arb_pkg::ARB_WAIT)
			assert (!cache_req.val)
				else $error("cache request issued in ARB_WAIT");
	end

endmodule

// File: hw/arb_fsm.sv
`timescale 1ns/100ps

module arb_fsm
(
	input  logic                   clk,
	input  logic                   nrst,

	// Pipeline status from the core
	input  logic                   mem_pending,     // Memory op in issue stage
	input  logic                   fetch_hold,      // Front end held by scoreboard
	input  logic                   fetch_wait_resp, // Fetch request outstanding
	input  logic                   mem_done,        // Memory op finished

	input  logic                   resp_val,        // Cache response valid

	output l15_arb_pkg::arb_state_t state,
	output logic                   mem_stall,
	output logic                   mem_granted
);

	l15_arb_pkg::arb_state_t state_nxt;

	logic switch_req;
	logic fetch_drained;
	logic mem_release;

	// A switch may only start while the front end is free to move
	assign switch_req    = mem_pending && !fetch_hold;

	// Last fetch response arrives while fetch still waits on it
	assign fetch_drained = fetch_wait_resp && resp_val;

	assign mem_release   = mem_done && !mem_pending;

	always_comb
	begin
		state_nxt = state;
		case (state)
			l15_arb_pkg::ARB_FETCH:
			begin
				if (switch_req)
					state_nxt = l15_arb_pkg::ARB_WAIT;
			end
			l15_arb_pkg::ARB_WAIT:
			begin
				if (fetch_drained)
					state_nxt = l15_arb_pkg::ARB_MEM;
			end
			l15_arb_pkg::ARB_MEM:
			begin
				if (mem_release)
					state_nxt = l15_arb_pkg::ARB_FETCH;
			end
			default:
				state_nxt = l15_arb_pkg::ARB_FETCH; // Recover from bad encoding
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			state <= l15_arb_pkg::ARB_FETCH;
		else
			state <= state_nxt;
	end

	// Flags lag the state by one edge on entry to the data grant
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			mem_stall   <= 1'b0;
			mem_granted <= 1'b0;
		end
		else
		begin
			case (state)
				l15_arb_pkg::ARB_FETCH:
				begin
					if (switch_req)
						mem_stall <= 1'b1; // Hold issue until data owns the port
				end
				l15_arb_pkg::ARB_MEM:
				begin
					mem_stall   <= 1'b0;
					mem_granted <= !mem_release; // Drops together with the return
				end
				l15_arb_pkg::ARB_WAIT:
				begin
					mem_granted <= 1'b0;
				end
				default:
				begin
					mem_stall   <= 1'b0;
					mem_granted <= 1'b0;
				end
			endcase
		end
	end

	// Grant flag never outlives the data state
	a_granted_in_mem: assert property (@(posedge clk) disable iff (!nrst)
		mem_granted |-> (state == l15_arb_pkg::ARB_MEM))
		else $error("mem_granted high outside ARB_MEM");

	// Only three of the four encodings are legal
	a_state_legal: assert property (@(posedge clk) disable iff (!nrst)
		state != 2'b11)
		else $error("arbiter state reached unused encoding");

endmodule

// File: hw/l15_arb_pkg.sv
package l15_arb_pkg;

	// OpenPiton L1.5 transducer field widths
	localparam int ADDR_W   = 32;
	localparam int DATA_W   = 64;
	localparam int RQTYPE_W = 5;
	localparam int SIZE_W   = 3;
	localparam int RTYPE_W  = 4; // Client side returntype width

	// Owner of the single cache port
	typedef enum logic [1:0]
	{
		ARB_FETCH = 2'd0, // Instruction fetch connected
		ARB_WAIT  = 2'd1, // Data access waiting for fetch to drain
		ARB_MEM   = 2'd2  // Data memory connected
	} arb_state_t;

	// Request towards the L1.5, held until ack
	typedef struct packed
	{
		logic [RQTYPE_W-1:0] rqtype;
		logic [SIZE_W-1:0]   size;
		logic [ADDR_W-1:0]   address;
		logic [DATA_W-1:0]   data;
		logic                val;
	} l15_req_t;

	// Response from the L1.5, valid for one cycle
	typedef struct packed
	{
		logic               val;
		logic [DATA_W-1:0]  data_0;
		logic [DATA_W-1:0]  data_1;
		logic [RTYPE_W-1:0] returntype;
	} l15_resp_t;

	// Acknowledges returned for a request
	typedef struct packed
	{
		logic ack;
		logic header_ack;
	} l15_ack_t;

endpackage
